//--- flist.f
verilog/core_pkg.sv
verilog/rst_sync_chain.sv
verilog/core_rst_ctrl.sv
verilog/req_retiming.sv
verilog/core_top.sv
tests/core_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f flist.f \
    --top-module core_top_tb \
    --Mdir obj_dir \
    -o core_top_sim

./obj_dir/core_top_sim | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "No errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"

//--- tests/core_top_tb.sv
/* Core top testbench */

`timescale 1ns/10ps

module core_top_tb
    import core_pkg::*;
;

    localparam int S          = RST_SYNC_STAGES;
    localparam int NUM_ROWS   = 24;
    localparam int MAX_DELAY  = 12;       // Long delay, forces back-pressure
    localparam int CLK_PERIOD = 4;
    localparam int WATCHDOG_NS = ((3 * NUM_ROWS + 4) * (MAX_DELAY + 4) + 400) * CLK_PERIOD;

    // One stimulus row, also the expected memory-side item
    typedef struct {
        logic        dmem;      // Port select
        logic        cmd;
        logic [2:0]  bl;
        logic [1:0]  width;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          delay;     // Cycles before the memory acknowledge
    } row_t;

    logic        clk;
    logic        reset_i;
    logic        sys_rst_req_i, cpu_rst_req_i;
    logic        core_rst_o, core_rdc_qlfy_o, core_rst_status_o;
    logic        pipe_imem_req_i, pipe_imem_cmd_i, pipe_imem_ack_o;
    logic [31:0] pipe_imem_addr_i;
    logic [2:0]  pipe_imem_bl_i;
    logic        mem_imem_req_o, mem_imem_cmd_o, mem_imem_ack_i;
    logic [31:0] mem_imem_addr_o;
    logic [2:0]  mem_imem_bl_o;
    logic        pipe_dmem_req_i, pipe_dmem_cmd_i, pipe_dmem_ack_o;
    logic [1:0]  pipe_dmem_width_i;
    logic [31:0] pipe_dmem_addr_i, pipe_dmem_wdata_i;
    logic        mem_dmem_req_o, mem_dmem_cmd_o, mem_dmem_ack_i;
    logic [1:0]  mem_dmem_width_o;
    logic [31:0] mem_dmem_addr_o, mem_dmem_wdata_o;

    row_t        stim [NUM_ROWS];
    row_t        imem_q [$];        // Accepted, not yet delivered
    row_t        dmem_q [$];
    int          imem_wait, dmem_wait;
    int          imem_accepts;
    int          errors;
    logic        hold_ack;          // Withholds the imem acknowledge
    int          ack_budget;        // Acks allowed while held
    logic [31:0] lfsr_q;
    logic [7:0]  rst_hist;          // core_rst_o, newest in bit 0
    int          hist_cnt;
    logic        prev_core_rst;

    core_top core_top_inst (
        .clk (clk), .reset_i (reset_i),
        .sys_rst_req_i (sys_rst_req_i), .cpu_rst_req_i (cpu_rst_req_i),
        .core_rst_o (core_rst_o), .core_rdc_qlfy_o (core_rdc_qlfy_o),
        .core_rst_status_o (core_rst_status_o),
        .pipe_imem_req_i (pipe_imem_req_i), .pipe_imem_cmd_i (pipe_imem_cmd_i),
        .pipe_imem_addr_i (pipe_imem_addr_i), .pipe_imem_bl_i (pipe_imem_bl_i),
        .pipe_imem_ack_o (pipe_imem_ack_o),
        .mem_imem_req_o (mem_imem_req_o), .mem_imem_cmd_o (mem_imem_cmd_o),
        .mem_imem_addr_o (mem_imem_addr_o), .mem_imem_bl_o (mem_imem_bl_o),
        .mem_imem_ack_i (mem_imem_ack_i),
        .pipe_dmem_req_i (pipe_dmem_req_i), .pipe_dmem_cmd_i (pipe_dmem_cmd_i),
        .pipe_dmem_width_i (pipe_dmem_width_i), .pipe_dmem_addr_i (pipe_dmem_addr_i),
        .pipe_dmem_wdata_i (pipe_dmem_wdata_i), .pipe_dmem_ack_o (pipe_dmem_ack_o),
        .mem_dmem_req_o (mem_dmem_req_o), .mem_dmem_cmd_o (mem_dmem_cmd_o),
        .mem_dmem_width_o (mem_dmem_width_o), .mem_dmem_addr_o (mem_dmem_addr_o),
        .mem_dmem_wdata_o (mem_dmem_wdata_o), .mem_dmem_ack_i (mem_dmem_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------
    function automatic logic lfsr_step();
        logic lsb;
        lsb    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) lfsr_q = lfsr_q ^ 32'hA300_0000;   // Taps 32, 30, 26, 25
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) val = {val[30:0], lfsr_step()};
        return val;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic fill_table();
        logic [31:0] r;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rand_bits(1);
            stim[i].dmem  = r[0];
            r = rand_bits(1);
            stim[i].cmd   = r[0];
            r = rand_bits(3);
            stim[i].bl    = r[2:0];
            r = rand_bits(2);
            stim[i].width = (r[1:0] == 2'b11) ? 2'b10 : r[1:0];   // No reserved code
            stim[i].addr  = rand_bits(32);
            stim[i].wdata = rand_bits(32);
            r = rand_bits(3);
            stim[i].delay = int'(r[2:0]);
            if (i % 4 == 0) stim[i].delay = 0;
            if (i % 5 == 3) stim[i].delay = MAX_DELAY;
        end
    endtask

    // Holds one item until accepted, pauses while the core is in reset
    task automatic drive_imem(input row_t r);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            pipe_imem_req_i  <= ~core_rst_o;
            pipe_imem_cmd_i  <= r.cmd;
            pipe_imem_addr_i <= r.addr;
            pipe_imem_bl_i   <= r.bl;
            @(posedge clk);
            if (pipe_imem_req_i && pipe_imem_ack_o && !core_rst_o) begin
                accepted = 1'b1;
                imem_q.push_back(r);
                imem_accepts++;
            end
        end
    endtask

    task automatic drive_dmem(input row_t r);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            pipe_dmem_req_i   <= ~core_rst_o;
            pipe_dmem_cmd_i   <= r.cmd;
            pipe_dmem_width_i <= r.width;
            pipe_dmem_addr_i  <= r.addr;
            pipe_dmem_wdata_i <= r.wdata;
            @(posedge clk);
            if (pipe_dmem_req_i && pipe_dmem_ack_o && !core_rst_o) begin
                accepted = 1'b1;
                dmem_q.push_back(r);
            end
        end
    endtask

    task automatic play_table(input logic dmem);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (stim[i].dmem == dmem && dmem) drive_dmem(stim[i]);
            if (stim[i].dmem == dmem && !dmem) drive_imem(stim[i]);
        end
        if (dmem) pipe_dmem_req_i <= 1'b0;
        else pipe_imem_req_i <= 1'b0;
    endtask

    // Queue sizes settle by the falling edge
    task automatic wait_drain();
        @(negedge clk);
        while (imem_q.size() > 0 || dmem_q.size() > 0) @(negedge clk);
        repeat (2) @(posedge clk);
    endtask

    // Samples after each edge i = 1..S+2 following a change at an edge
    task automatic check_rst_steps(input logic entering, input string what);
        logic exp_rst;
        logic exp_qlfy;
        for (int i = 1; i <= S + 2; i++) begin
            @(posedge clk);
            @(negedge clk);
            exp_rst  = entering ? (i >= S + 2) : (i <= S);
            exp_qlfy = entering ? (i <= S) : (i >= S + 2);
            if (core_rst_o !== exp_rst || core_rdc_qlfy_o !== exp_qlfy)
                report_mismatch($sformatf("%s step %0d: rst %b qlfy %b, expected %b %b",
                    what, i, core_rst_o, core_rdc_qlfy_o, exp_rst, exp_qlfy));
        end
    endtask

    task automatic pulse_request(input logic use_sys);
        @(posedge clk);
        if (use_sys) sys_rst_req_i <= 1'b1;
        else cpu_rst_req_i <= 1'b1;
        check_rst_steps(1'b1, use_sys ? "sys entry" : "cpu entry");
        repeat (S + 2) @(posedge clk);      // Let status catch up
        if (use_sys) sys_rst_req_i <= 1'b0;
        else cpu_rst_req_i <= 1'b0;
        check_rst_steps(1'b0, use_sys ? "sys release" : "cpu release");
        repeat (S + 2) @(posedge clk);
    endtask

    //------------------------------------------------------------
    // Memory responders, compare the head with the scoreboard
    //------------------------------------------------------------
    always @(posedge clk) begin : imem_responder
        row_t head;
        mem_imem_ack_i <= 1'b0;
        if (reset_i || core_rst_o) begin
            imem_q.delete();                // Flushed items never arrive
            imem_wait = 0;
        end else if (mem_imem_req_o) begin
            if (imem_q.size() == 0) begin
                report_mismatch("imem request with no pending item");
            end else begin
                head = imem_q[0];
                if (mem_imem_cmd_o !== head.cmd || mem_imem_addr_o !== head.addr ||
                    mem_imem_bl_o !== head.bl)
                    report_mismatch($sformatf("imem got %b %h %h, expected %b %h %h",
                        mem_imem_cmd_o, mem_imem_addr_o, mem_imem_bl_o,
                        head.cmd, head.addr, head.bl));
                if (mem_imem_ack_i) begin
                    void'(imem_q.pop_front());
                    imem_wait = 0;
                end else if (imem_wait >= head.delay && (!hold_ack || ack_budget > 0)) begin
                    mem_imem_ack_i <= 1'b1;
                    if (hold_ack) ack_budget--;
                end else begin
                    imem_wait++;
                end
            end
        end
    end

    always @(posedge clk) begin : dmem_responder
        row_t head;
        mem_dmem_ack_i <= 1'b0;
        if (reset_i || core_rst_o) begin
            dmem_q.delete();
            dmem_wait = 0;
        end else if (mem_dmem_req_o) begin
            if (dmem_q.size() == 0) begin
                report_mismatch("dmem request with no pending item");
            end else begin
                head = dmem_q[0];
                if (mem_dmem_cmd_o !== head.cmd || mem_dmem_width_o !== head.width ||
                    mem_dmem_addr_o !== head.addr || mem_dmem_wdata_o !== head.wdata)
                    report_mismatch($sformatf("dmem got %b %b %h %h, expected %b %b %h %h",
                        mem_dmem_cmd_o, mem_dmem_width_o, mem_dmem_addr_o, mem_dmem_wdata_o,
                        head.cmd, head.width, head.addr, head.wdata));
                if (mem_dmem_ack_i) begin
                    void'(dmem_q.pop_front());
                    dmem_wait = 0;
                end else if (dmem_wait >= head.delay) begin
                    mem_dmem_ack_i <= 1'b1;
                end else begin
                    dmem_wait++;
                end
            end
        end
    end

    // Status lags core reset by S cycles, requests quiet in core reset
    always @(negedge clk) begin
        if (hist_cnt >= S && core_rst_status_o !== rst_hist[S-1])
            report_mismatch($sformatf("status %b, expected %b", core_rst_status_o,
                rst_hist[S-1]));
        if (core_rst_o && prev_core_rst && (mem_imem_req_o || mem_dmem_req_o))
            report_mismatch("memory request during core reset");
        if (core_rst_o && (pipe_imem_ack_o || pipe_dmem_ack_o))
            report_mismatch("pipe acknowledge during core reset");
        rst_hist      = {rst_hist[6:0], core_rst_o};
        prev_core_rst = core_rst_o;
        if (hist_cnt < 8) hist_cnt++;
    end

    //------------------------------------------------------------
    // Watchdog
    //------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        int base;
        errors            = 0;
        imem_accepts      = 0;
        hist_cnt          = 0;
        rst_hist          = '0;
        prev_core_rst     = 1'b0;
        hold_ack          = 1'b0;
        ack_budget        = 0;
        imem_wait         = 0;
        dmem_wait         = 0;
        lfsr_q            = 32'd90801;
        reset_i           = 1'b1;
        sys_rst_req_i     = 1'b0;
        cpu_rst_req_i     = 1'b0;
        pipe_imem_req_i   = 1'b1;     // Requests held through reset
        pipe_imem_cmd_i   = 1'b0;
        pipe_imem_addr_i  = '0;
        pipe_imem_bl_i    = '0;
        pipe_dmem_req_i   = 1'b1;
        pipe_dmem_cmd_i   = 1'b0;
        pipe_dmem_width_i = '0;
        pipe_dmem_addr_i  = '0;
        pipe_dmem_wdata_i = '0;
        mem_imem_ack_i    = 1'b0;
        mem_dmem_ack_i    = 1'b0;
        fill_table();

        // Reset values, retimers see core reset from the second edge
        for (int i = 0; i < 7; i++) begin
            @(negedge clk);
            if (core_rst_o !== 1'b1 || core_rdc_qlfy_o !== 1'b0 ||
                pipe_imem_ack_o !== 1'b0 || pipe_dmem_ack_o !== 1'b0)
                report_mismatch("outputs wrong during reset");
            if (i > 0 && (mem_imem_req_o !== 1'b0 || mem_dmem_req_o !== 1'b0))
                report_mismatch("memory request during reset");
        end
        @(posedge clk);
        reset_i         <= 1'b0;
        pipe_imem_req_i <= 1'b0;
        pipe_dmem_req_i <= 1'b0;
        check_rst_steps(1'b0, "power-up release");

        pulse_request(1'b0);
        pulse_request(1'b1);

        // Table traffic on both ports
        fork
            play_table(1'b0);
            play_table(1'b1);
        join
        wait_drain();

        // Back-pressure on imem
        hold_ack = 1'b1;
        ack_budget = 0;
        base = imem_accepts;
        fork
            begin
                for (int i = 0; i < 4; i++) drive_imem(stim[i]);
                pipe_imem_req_i <= 1'b0;
            end
        join_none
        repeat (12) @(posedge clk);
        if (imem_accepts - base != 2)
            report_mismatch($sformatf("%0d accepted while held, expected 2", imem_accepts - base));
        ack_budget = 1;
        repeat (12) @(posedge clk);
        if (imem_accepts - base != 3)
            report_mismatch($sformatf("%0d accepted after one ack, expected 3", imem_accepts - base));
        hold_ack = 1'b0;
        wait fork;
        wait_drain();

        // Flush during traffic, then traffic resumes
        fork
            play_table(1'b0);
            play_table(1'b1);
            begin
                repeat (10) @(posedge clk);
                cpu_rst_req_i <= 1'b1;
                repeat (3) @(posedge clk);
                cpu_rst_req_i <= 1'b0;
            end
        join
        wait_drain();
        fork
            play_table(1'b0);
            play_table(1'b1);
        join
        wait_drain();

        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : core_top_tb

//--- verilog/core_top.sv
/* Core top, reset and retiming */

`timescale 1ns/10ps

module core_top
    import core_pkg::*;
#(
    parameter int unsigned SYNC_STAGES = RST_SYNC_STAGES,
    parameter int unsigned IMEM_AW     = IMEM_AWIDTH,   // Must equal IMEM_AWIDTH
    parameter int unsigned DMEM_AW     = DMEM_AWIDTH    // Must equal DMEM_AWIDTH
) (
    input  logic                   clk,
    input  logic                   reset_i,             // Power-up reset
    input  logic                   sys_rst_req_i,
    input  logic                   cpu_rst_req_i,
    output logic                   core_rst_o,
    output logic                   core_rdc_qlfy_o,
    output logic                   core_rst_status_o,
    // Pipeline instruction requests
    input  logic                   pipe_imem_req_i,
    input  logic                   pipe_imem_cmd_i,
    input  logic [IMEM_AW-1:0]     pipe_imem_addr_i,
    input  logic [IMEM_BSIZE-1:0]  pipe_imem_bl_i,
    output logic                   pipe_imem_ack_o,
    // Instruction memory
    output logic                   mem_imem_req_o,
    output logic                   mem_imem_cmd_o,
    output logic [IMEM_AW-1:0]     mem_imem_addr_o,
    output logic [IMEM_BSIZE-1:0]  mem_imem_bl_o,
    input  logic                   mem_imem_ack_i,
    // Pipeline data requests
    input  logic                   pipe_dmem_req_i,
    input  logic                   pipe_dmem_cmd_i,
    input  logic [1:0]             pipe_dmem_width_i,
    input  logic [DMEM_AW-1:0]     pipe_dmem_addr_i,
    input  logic [DMEM_DWIDTH-1:0] pipe_dmem_wdata_i,
    output logic                   pipe_dmem_ack_o,
    // Data memory
    output logic                   mem_dmem_req_o,
    output logic                   mem_dmem_cmd_o,
    output logic [1:0]             mem_dmem_width_o,
    output logic [DMEM_AW-1:0]     mem_dmem_addr_o,
    output logic [DMEM_DWIDTH-1:0] mem_dmem_wdata_o,
    input  logic                   mem_dmem_ack_i
);

    logic      core_rst;        // Reset for both retimers
    imem_req_t pipe_imem_data;
    imem_req_t mem_imem_data;
    dmem_req_t pipe_dmem_data;
    dmem_req_t mem_dmem_data;

    //------------------------------------------------------------
    // Reset generation
    //------------------------------------------------------------
    core_rst_ctrl #(
        .SYNC_STAGES       (SYNC_STAGES)
    ) u_rst_ctrl (
        .clk               (clk),
        .reset_i           (reset_i),
        .sys_rst_req_i     (sys_rst_req_i),
        .cpu_rst_req_i     (cpu_rst_req_i),
        .core_rst_o        (core_rst),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .core_rst_status_o (core_rst_status_o)
    );

    assign core_rst_o = core_rst;

    //------------------------------------------------------------
    // Instruction request path
    //------------------------------------------------------------
    assign pipe_imem_data.cmd  = mem_cmd_e'(pipe_imem_cmd_i);
    assign pipe_imem_data.addr = pipe_imem_addr_i;
    assign pipe_imem_data.bl   = pipe_imem_bl_i;

    req_retiming #(
        .req_t       (imem_req_t)
    ) u_imem_retim (
        .clk         (clk),
        .reset_i     (core_rst),
        .pipe_req_i  (pipe_imem_req_i),
        .pipe_data_i (pipe_imem_data),
        .pipe_ack_o  (pipe_imem_ack_o),
        .mem_req_o   (mem_imem_req_o),
        .mem_data_o  (mem_imem_data),
        .mem_ack_i   (mem_imem_ack_i)
    );

    assign mem_imem_cmd_o  = mem_imem_data.cmd;
    assign mem_imem_addr_o = mem_imem_data.addr;
    assign mem_imem_bl_o   = mem_imem_data.bl;

    //------------------------------------------------------------
    // Data request path
    //------------------------------------------------------------
    assign pipe_dmem_data.cmd   = mem_cmd_e'(pipe_dmem_cmd_i);
    assign pipe_dmem_data.width = mem_width_e'(pipe_dmem_width_i);
    assign pipe_dmem_data.addr  = pipe_dmem_addr_i;
    assign pipe_dmem_data.wdata = pipe_dmem_wdata_i;

    req_retiming #(
        .req_t       (dmem_req_t)
    ) u_dmem_retim (
        .clk         (clk),
        .reset_i     (core_rst),
        .pipe_req_i  (pipe_dmem_req_i),
        .pipe_data_i (pipe_dmem_data),
        .pipe_ack_o  (pipe_dmem_ack_o),
        .mem_req_o   (mem_dmem_req_o),
        .mem_data_o  (mem_dmem_data),
        .mem_ack_i   (mem_dmem_ack_i)
    );

    assign mem_dmem_cmd_o   = mem_dmem_data.cmd;
    assign mem_dmem_width_o = mem_dmem_data.width;
    assign mem_dmem_addr_o  = mem_dmem_data.addr;
    assign mem_dmem_wdata_o = mem_dmem_data.wdata;

endmodule : core_top

//--- verilog/req_retiming.sv
/* Two-entry request retimer */

`timescale 1ns/10ps

module req_retiming #(
    parameter type req_t = logic
) (
    input  logic clk,
    input  logic reset_i,           // Core reset, flushes the buffer
    // Pipeline side
    input  logic pipe_req_i,
    input  req_t pipe_data_i,
    output logic pipe_ack_o,        // Push strobe
    // Memory side
    output logic mem_req_o,
    output req_t mem_data_o,        // Head entry
    input  logic mem_ack_i          // Pop strobe
);

    localparam int unsigned DEPTH = 2;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    req_t             buf_q [DEPTH];    // Payload storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;          // Fill level, 0..DEPTH
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    //------------------------------------------------------------
    // Handshake decode
    //------------------------------------------------------------
    assign full  = (count_q == CNT_W'(DEPTH));
    assign empty = (count_q == '0);

    assign push = pipe_req_i & ~full & ~reset_i;   // Accept while room is left and out of reset
    assign pop  = mem_req_o & mem_ack_i;

    assign pipe_ack_o = push;
    assign mem_req_o  = ~empty;         // Held until acknowledged
    assign mem_data_o = buf_q[rd_ptr_q];

    //------------------------------------------------------------
    // Pointers and fill level
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;    // Wraps at DEPTH
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Both or neither
            endcase
        end
    end

    // Payload write
    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr_q] <= pipe_data_i;
        end
    end

endmodule : req_retiming

//--- verilog/core_rst_ctrl.sv
/* Core reset controller */

`timescale 1ns/10ps

module core_rst_ctrl
    import core_pkg::*;
#(
    parameter int unsigned SYNC_STAGES = RST_SYNC_STAGES
) (
    input  logic clk,
    input  logic reset_i,               // Power-up reset
    input  logic sys_rst_req_i,         // System reset request, async
    input  logic cpu_rst_req_i,         // CPU reset request, async
    output logic core_rst_o,            // Core reset, active high
    output logic core_rdc_qlfy_o,       // Low while core reset is in motion
    output logic core_rst_status_o      // Synchronized core reset
);

    logic sys_rst_req_sync;
    logic cpu_rst_req_sync;
    logic rst_req_sync;     // Either request, synchronized
    logic core_rst_q;
    logic rdc_qlfy_q;

    //------------------------------------------------------------
    // Request synchronizers
    //------------------------------------------------------------
    // Both chains come out of reset reporting an active request,
    // so the core stays in reset until they have flushed
    rst_sync_chain #(
        .STAGES  (SYNC_STAGES),
        .RST_VAL (1'b1)
    ) u_sys_req_sync (
        .clk     (clk),
        .reset_i (reset_i),
        .d_i     (sys_rst_req_i),
        .q_o     (sys_rst_req_sync)
    );

    rst_sync_chain #(
        .STAGES  (SYNC_STAGES),
        .RST_VAL (1'b1)
    ) u_cpu_req_sync (
        .clk     (clk),
        .reset_i (reset_i),
        .d_i     (cpu_rst_req_i),
        .q_o     (cpu_rst_req_sync)
    );

    assign rst_req_sync = sys_rst_req_sync | cpu_rst_req_sync;

    //------------------------------------------------------------
    // Qualifier and reset sequencer
    //------------------------------------------------------------
    // Entry: qualifier drops first, reset follows a cycle later
    // Exit: reset drops first, qualifier returns a cycle later
    always_ff @(posedge clk) begin
        if (reset_i) begin
            core_rst_q <= 1'b1;
            rdc_qlfy_q <= 1'b0;
        end else begin
            core_rst_q <= rst_req_sync & (core_rst_q | ~rdc_qlfy_q);  // Waits for qlfy low
            rdc_qlfy_q <= ~rst_req_sync & ~core_rst_q;                // Waits for reset low
        end
    end

    // Status seen through its own chain
    rst_sync_chain #(
        .STAGES  (SYNC_STAGES),
        .RST_VAL (1'b1)
    ) u_status_sync (
        .clk     (clk),
        .reset_i (reset_i),
        .d_i     (core_rst_q),
        .q_o     (core_rst_status_o)
    );

    assign core_rst_o      = core_rst_q;
    assign core_rdc_qlfy_o = rdc_qlfy_q;

endmodule : core_rst_ctrl

//--- verilog/rst_sync_chain.sv
/* Reset synchronizer chain */

`timescale 1ns/10ps

module rst_sync_chain
    import core_pkg::*;
#(
    parameter int unsigned STAGES  = RST_SYNC_STAGES,  // Two or more
    parameter logic        RST_VAL = 1'b1              // Value held during reset
) (
    input  logic clk,
    input  logic reset_i,
    input  logic d_i,
    output logic q_o
);

    logic [STAGES-1:0] sync_q;  // Stage 0 samples d_i

    // Shift register, whole chain preset on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_q <= {STAGES{RST_VAL}};
        end else begin
            sync_q <= {sync_q[STAGES-2:0], d_i};
        end
    end

    assign q_o = sync_q[STAGES-1];  // Last stage only

endmodule : rst_sync_chain

//--- verilog/core_pkg.sv
/* Core memory request types */

package core_pkg;

    //------------------------------------------------------------
    // Memory interface widths
    //------------------------------------------------------------
    localparam int unsigned IMEM_AWIDTH     = 32;   // Instruction address
    localparam int unsigned IMEM_BSIZE      = 3;    // Burst length field
    localparam int unsigned DMEM_AWIDTH     = 32;   // Data address
    localparam int unsigned DMEM_DWIDTH     = 32;   // Data write bus

    // Default depth of the reset synchronizers
    localparam int unsigned RST_SYNC_STAGES = 2;

    //------------------------------------------------------------
    // Command and access size encodings
    //------------------------------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10   // 2'b11 unused
    } mem_width_e;

    // Instruction fetch request, 36 bits
    typedef struct packed {
        mem_cmd_e                   cmd;
        logic [IMEM_AWIDTH-1:0]     addr;
        logic [IMEM_BSIZE-1:0]      bl;     // Burst length
    } imem_req_t;

    // Load/store request, 67 bits
    typedef struct packed {
        mem_cmd_e                   cmd;
        mem_width_e                 width;
        logic [DMEM_AWIDTH-1:0]     addr;
        logic [DMEM_DWIDTH-1:0]     wdata;  // Ignored on reads
    } dmem_req_t;

endpackage : core_pkg
